//--- project.f
+incdir+include
src/adce_pkg.sv
src/adce_trigger.sv
src/adce_mode_ctrl.sv
src/adce_sequencer.sv
src/adce_reconfig_driver.sv
testbench/tb_adce_reconfig_driver.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the ADCE driver testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert -f project.f --top-module tb_adce_reconfig_driver -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
   echo "run_sim: passed"
else
   echo "run_sim: failed, see sim.log"
   exit 1
fi

//--- testbench/tb_adce_reconfig_driver.sv
`timescale 1ns/1ps
`include "adce_cfg.svh"

module tb_adce_reconfig_driver;
   import adce_pkg::*;

   typedef logic [38:0] wr_list_t[$];

   localparam int MODE_OFF      = 0;
   localparam int MODE_ONE_TIME = 1;

   logic        reconfig_xcvr_clk = 1'b0;
   logic        mgmt_rst_reset = 1'b1;
   logic [4:0]  ltssm_state = 5'd0;
   logic        ev1us = 1'b0;
   logic [1:0]  current_speed = `SPEED_GEN3;
   logic        reconfig_busy = 1'b0;
   logic        reconfig_mgmt_waitrequest = 1'b0;
   mgmt_write_t reconfig_mgmt;
   logic        adce_trig_done;

   logic [31:0] rnd_state = 32'h13ce_94a6;
   logic        stall_en = 1'b0;
   logic [4:0]  ltssm_prev = 5'd0;
   mgmt_write_t prev_mgmt = '0;
   logic        prev_wait = 1'b0;
   logic        prev_busy = 1'b0;
   int          ticks = 0;
   wr_list_t    got_q;
   wr_list_t    exp_q;
   int          exp_modes[$];
   int          run_count = 0;
   int          accepted_count = 0;
   int          error_count = 0;
   int          timeout_count = 0;

   adce_reconfig_driver i_dut (.*);

   always #5 reconfig_xcvr_clk = ~reconfig_xcvr_clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // offset, mode, then per channel an LCH write and a go except channel 4 and the last
   function automatic wr_list_t expected_writes(input int mode);
      wr_list_t l;
      l.push_back({`ADDR_ADCE_OFFSET, 32'd0});
      l.push_back({`ADDR_ADCE_DATA, 32'(mode)});
      for (int ch = 0; ch < `ADCE_NUM_CHANNELS; ch++) begin
         l.push_back({`ADDR_ADCE_LCH, 32'(ch)});
         if (ch != `ADCE_SKIP_CHANNEL && ch != `ADCE_NUM_CHANNELS - 1) begin
            l.push_back({`ADDR_ADCE_STATUS, 32'd1});
         end
      end
      return l;
   endfunction

   task automatic report(input string msg);
      error_count++;
      $display("error at %0d ns: %s", $time, msg);
   endtask

   task automatic end_run();
      $display("runs %0d, errors %0d, timeouts %0d", run_count, error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   endtask

   task automatic wait_for(input bit on_writes, input int target, input int limit);
      int cycles;
      cycles = 0;
      while (timeout_count == 0 && (on_writes ? accepted_count : run_count) < target &&
             cycles < limit) begin
         @(posedge reconfig_xcvr_clk);
         cycles++;
      end
      if (timeout_count == 0 && (on_writes ? accepted_count : run_count) < target) begin
         $display("timeout: %0s count did not reach %0d within %0d cycles",
                  on_writes ? "write" : "run", target, limit);
         timeout_count++;
      end
   endtask

   task automatic enter_eq_ph2();
      @(posedge reconfig_xcvr_clk);
      ltssm_state <= 5'd0;
      @(posedge reconfig_xcvr_clk);
      ltssm_state <= `LTSSM_EQ_PH2;
   endtask

   // ev1us every other cycle and random bus stalls on request
   always @(posedge reconfig_xcvr_clk) begin
      ev1us <= ~ev1us & ~mgmt_rst_reset;
      rnd_state = lcg_next(rnd_state);
      reconfig_mgmt_waitrequest <= stall_en & rnd_state[28];
      reconfig_busy             <= stall_en & rnd_state[31] & rnd_state[30];
   end

   // bus monitor and run checker
   always @(posedge reconfig_xcvr_clk) begin
      if (!mgmt_rst_reset) begin
         if (ltssm_state == `LTSSM_EQ_PH2 && ltssm_prev != `LTSSM_EQ_PH2) begin
            ticks = 0;
         end else if (ev1us) begin
            ticks++;
         end
         if (prev_mgmt.write && prev_wait && reconfig_mgmt !== prev_mgmt) begin
            report("write changed while waitrequest was high");
         end
         if (reconfig_mgmt.write && !(prev_mgmt.write && prev_wait) && prev_busy) begin
            report("write issued while reconfig_busy was high");
         end
         if (reconfig_mgmt.write && !reconfig_mgmt_waitrequest) begin
            got_q.push_back({reconfig_mgmt.address, reconfig_mgmt.writedata});
            accepted_count <= accepted_count + 1;
            if (ticks < `ADCE_TIMER) begin
               report($sformatf("write accepted after only %0d ticks", ticks));
            end
         end
         if (adce_trig_done) begin
            run_count <= run_count + 1;
            if (exp_modes.size() == 0) begin
               report("done pulse with no run expected");
            end else begin
               exp_q = expected_writes(exp_modes.pop_front());
               if (got_q.size() != exp_q.size()) begin
                  report($sformatf("%0d writes, expected %0d", got_q.size(), exp_q.size()));
               end
               for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
                  if (got_q[i] !== exp_q[i]) begin
                     report($sformatf("write %0d is %h/%h, expected %h/%h", i,
                        got_q[i][38:32], got_q[i][31:0], exp_q[i][38:32], exp_q[i][31:0]));
                  end
               end
            end
            got_q.delete();
         end
      end
      ltssm_prev = ltssm_state;
      prev_mgmt  = reconfig_mgmt;
      prev_wait  = reconfig_mgmt_waitrequest;
      prev_busy  = reconfig_busy;
   end

   initial begin
      repeat (8) @(posedge reconfig_xcvr_clk);
      mgmt_rst_reset <= 1'b0;
      // quiet link at gen3
      repeat (200) begin
         @(posedge reconfig_xcvr_clk);
         if (reconfig_mgmt.write || adce_trig_done) begin
            report("write or done seen without a trigger");
         end
      end
      // on run after phase 2 and the 4 ms timer
      exp_modes.push_back(MODE_ONE_TIME);
      enter_eq_ph2();
      wait_for(1'b0, 1, 20000);
      // same run with random waitrequest and busy
      stall_en <= 1'b1;
      exp_modes.push_back(MODE_ONE_TIME);
      enter_eq_ph2();
      wait_for(1'b0, 2, 40000);
      stall_en <= 1'b0;
      // speed drop out of gen3
      exp_modes.push_back(MODE_OFF);
      current_speed <= 2'd2;
      wait_for(1'b0, 3, 2000);
      current_speed <= `SPEED_GEN3;
      // power-down request arriving while an on run is busy
      exp_modes.push_back(MODE_ONE_TIME);
      exp_modes.push_back(MODE_OFF);
      enter_eq_ph2();
      wait_for(1'b1, accepted_count + 3, 20000);
      current_speed <= 2'd2;
      wait_for(1'b0, 5, 4000);
      repeat (100) @(posedge reconfig_xcvr_clk);
      if (run_count != 5 || exp_modes.size() != 0) begin
         report($sformatf("%0d done pulses seen, 5 expected", run_count));
      end
      end_run();
   end

endmodule

//--- src/adce_reconfig_driver.sv
`timescale 1ns/1ps

module adce_reconfig_driver (
   input  logic                  reconfig_xcvr_clk,
   input  logic                  mgmt_rst_reset,
   input  logic [4:0]            ltssm_state,
   input  logic                  ev1us,
   input  logic [1:0]            current_speed,
   input  logic                  reconfig_busy,
   input  logic                  reconfig_mgmt_waitrequest,
   output adce_pkg::mgmt_write_t reconfig_mgmt,
   output logic                  adce_trig_done
);
   import adce_pkg::*;

   adce_event_t events;
   adce_req_t   req;
   logic        seq_idle;

   adce_trigger i_trigger (
      .reconfig_xcvr_clk (reconfig_xcvr_clk),
      .mgmt_rst_reset    (mgmt_rst_reset),
      .ltssm_state       (ltssm_state),
      .ev1us             (ev1us),
      .current_speed     (current_speed),
      .events            (events)
   );

   adce_mode_ctrl i_mode_ctrl (
      .reconfig_xcvr_clk (reconfig_xcvr_clk),
      .mgmt_rst_reset    (mgmt_rst_reset),
      .events            (events),
      .seq_idle          (seq_idle),
      .req               (req)
   );

   adce_sequencer i_sequencer (
      .reconfig_xcvr_clk         (reconfig_xcvr_clk),
      .mgmt_rst_reset            (mgmt_rst_reset),
      .req                       (req),
      .reconfig_busy             (reconfig_busy),
      .reconfig_mgmt_waitrequest (reconfig_mgmt_waitrequest),
      .seq_idle                  (seq_idle),
      .reconfig_mgmt             (reconfig_mgmt),
      .adce_trig_done            (adce_trig_done)
   );

endmodule

//--- src/adce_sequencer.sv
`timescale 1ns/1ps
`include "adce_cfg.svh"

module adce_sequencer (
   input  logic                  reconfig_xcvr_clk,
   input  logic                  mgmt_rst_reset,
   input  adce_pkg::adce_req_t   req,
   input  logic                  reconfig_busy,
   input  logic                  reconfig_mgmt_waitrequest,
   output logic                  seq_idle,
   output adce_pkg::mgmt_write_t reconfig_mgmt,
   output logic                  adce_trig_done
);
   import adce_pkg::*;

   localparam int PAUSE_W = $clog2(`ADCE_PAUSE_CYCLES);
   localparam logic [`ADCE_CHAN_W-1:0] LAST_CHAN = `ADCE_CHAN_W'(`ADCE_NUM_CHANNELS - 1);
   localparam logic [`ADCE_CHAN_W-1:0] SKIP_CHAN = `ADCE_CHAN_W'(`ADCE_SKIP_CHANNEL);
   localparam logic [PAUSE_W-1:0]      PAUSE_LAST = PAUSE_W'(`ADCE_PAUSE_CYCLES - 1);

   adce_seq_state_e         state;
   adce_mode_e              mode_r;
   logic [`ADCE_CHAN_W-1:0] chan;
   logic [PAUSE_W-1:0]      pause_cnt;
   logic                    wr_accept;
   logic                    bus_free;
   logic                    issue;

   function automatic mgmt_write_t mgmt_wr(input logic [`MGMT_ADDR_W-1:0] addr,
                                           input logic [`MGMT_DATA_W-1:0] data);
      mgmt_write_t w;
      w.address   = addr;
      w.writedata = data;
      w.write     = 1'b1;
      return w;
   endfunction

   // bus is free when nothing is pending or the pending write goes through now
   assign wr_accept = reconfig_mgmt.write & ~reconfig_mgmt_waitrequest;
   assign bus_free  = ~reconfig_mgmt.write | ~reconfig_mgmt_waitrequest;
   assign issue     = bus_free & ~reconfig_busy;
   assign seq_idle  = (state == SEQ_IDLE);

   always_ff @(posedge reconfig_xcvr_clk or posedge mgmt_rst_reset) begin
      if (mgmt_rst_reset) begin
         state          <= SEQ_IDLE;
         mode_r         <= ADCE_MODE_OFF;
         chan           <= '0;
         pause_cnt      <= '0;
         reconfig_mgmt  <= '0;
         adce_trig_done <= 1'b0;
      end else begin
         adce_trig_done <= 1'b0;
         if (wr_accept) begin
            reconfig_mgmt.write <= 1'b0;
         end
         case (state)
            SEQ_IDLE: begin
               if (req.go) begin
                  mode_r <= req.mode;
                  chan   <= '0;
                  state  <= SEQ_OFFSET;
               end
            end
            SEQ_OFFSET: begin
               if (issue) begin
                  reconfig_mgmt <= mgmt_wr(`ADDR_ADCE_OFFSET, '0);
                  state         <= SEQ_MODE;
               end
            end
            SEQ_MODE: begin
               if (issue) begin
                  reconfig_mgmt <= mgmt_wr(`ADDR_ADCE_DATA, `MGMT_DATA_W'(mode_r));
                  state         <= SEQ_LCH;
               end
            end
            SEQ_LCH: begin
               if (issue) begin
                  reconfig_mgmt <= mgmt_wr(`ADDR_ADCE_LCH, `MGMT_DATA_W'(chan));
                  if (chan == LAST_CHAN) begin
                     state <= SEQ_DONE;
                  end else if (chan == SKIP_CHAN) begin
                     // no go for this channel, straight on to the next one
                     chan <= chan + 1'b1;
                  end else begin
                     state <= SEQ_GO;
                  end
               end
            end
            SEQ_GO: begin
               if (issue) begin
                  reconfig_mgmt <= mgmt_wr(`ADDR_ADCE_STATUS, `MGMT_DATA_W'(1));
                  pause_cnt     <= '0;
                  state         <= SEQ_PAUSE;
               end
            end
            SEQ_PAUSE: begin
               // counting starts on the go acceptance, the next LCH cycle is the last gap
               if (bus_free) begin
                  pause_cnt <= pause_cnt + 1'b1;
                  if (pause_cnt == PAUSE_LAST) begin
                     chan  <= chan + 1'b1;
                     state <= SEQ_LCH;
                  end
               end
            end
            SEQ_DONE: begin
               if (bus_free) begin
                  adce_trig_done <= 1'b1;
                  state          <= SEQ_IDLE;
               end
            end
            default: begin
               state <= SEQ_IDLE;
            end
         endcase
      end
   end

   a_hold_on_wait: assert property (@(posedge reconfig_xcvr_clk) disable iff (mgmt_rst_reset)
      (reconfig_mgmt.write && reconfig_mgmt_waitrequest) |=> $stable(reconfig_mgmt));

endmodule

//--- src/adce_mode_ctrl.sv
`timescale 1ns/1ps

module adce_mode_ctrl (
   input  logic                  reconfig_xcvr_clk,
   input  logic                  mgmt_rst_reset,
   input  adce_pkg::adce_event_t events,
   input  logic                  seq_idle,
   output adce_pkg::adce_req_t   req
);
   import adce_pkg::*;

   adce_ctlr_state_e state;

   always_ff @(posedge reconfig_xcvr_clk or posedge mgmt_rst_reset) begin
      if (mgmt_rst_reset) begin
         state    <= CTLR_IDLE;
         req.go   <= 1'b0;
         req.mode <= ADCE_MODE_OFF;
      end else begin
         req.go <= 1'b0;
         // power-down beats a simultaneous on, newest event replaces a pending one
         if (events.off_pulse) begin
            state <= CTLR_POWERDOWN;
         end else if (events.on_pulse) begin
            state <= CTLR_ON;
         end else if (seq_idle) begin
            case (state)
               CTLR_ON: begin
                  req.go   <= 1'b1;
                  req.mode <= ADCE_MODE_ONE_TIME;
                  state    <= CTLR_IDLE;
               end
               CTLR_POWERDOWN: begin
                  req.go   <= 1'b1;
                  req.mode <= ADCE_MODE_OFF;
                  state    <= CTLR_IDLE;
               end
               default: begin
                  state <= CTLR_IDLE;
               end
            endcase
         end
      end
   end

   // the sequencer only leaves idle after sampling go, so it must still be idle here
   a_go_when_idle: assert property (@(posedge reconfig_xcvr_clk) disable iff (mgmt_rst_reset)
      req.go |-> seq_idle);

endmodule

//--- src/adce_trigger.sv
`timescale 1ns/1ps
`include "adce_cfg.svh"

module adce_trigger (
   input  logic                  reconfig_xcvr_clk,
   input  logic                  mgmt_rst_reset,
   input  logic [4:0]            ltssm_state,
   input  logic                  ev1us,
   input  logic [1:0]            current_speed,
   output adce_pkg::adce_event_t events
);

   localparam logic [`ADCE_TIMER_W-1:0] TIMER_MAX = `ADCE_TIMER_W'(`ADCE_TIMER);

   logic [4:0]               ltssm_r;
   logic [1:0]               speed_r;
   logic [`ADCE_TIMER_W-1:0] timer_cnt;
   logic                     eq_ph2_entry;

   // first cycle of equalization phase 2
   assign eq_ph2_entry = (ltssm_state == `LTSSM_EQ_PH2) && (ltssm_r != `LTSSM_EQ_PH2);

   always_ff @(posedge reconfig_xcvr_clk or posedge mgmt_rst_reset) begin
      if (mgmt_rst_reset) begin
         ltssm_r          <= '0;
         timer_cnt        <= TIMER_MAX;
         events.on_pulse  <= 1'b0;
      end else begin
         ltssm_r         <= ltssm_state;
         events.on_pulse <= 1'b0;
         if (eq_ph2_entry) begin
            timer_cnt <= '0;
         end else if (ev1us && (timer_cnt < TIMER_MAX)) begin
            timer_cnt <= timer_cnt + 1'b1;
            // pulse together with the counter reaching its end
            if (timer_cnt == TIMER_MAX - 1'b1) begin
               events.on_pulse <= 1'b1;
            end
         end
      end
   end

   // leaving gen3 asks for a power-down run
   always_ff @(posedge reconfig_xcvr_clk or posedge mgmt_rst_reset) begin
      if (mgmt_rst_reset) begin
         speed_r          <= '0;
         events.off_pulse <= 1'b0;
      end else begin
         speed_r          <= current_speed;
         events.off_pulse <= (speed_r == `SPEED_GEN3) && (current_speed != `SPEED_GEN3);
      end
   end

   a_on_single: assert property (@(posedge reconfig_xcvr_clk) disable iff (mgmt_rst_reset)
      events.on_pulse |=> !events.on_pulse);

   a_off_single: assert property (@(posedge reconfig_xcvr_clk) disable iff (mgmt_rst_reset)
      events.off_pulse |=> !events.off_pulse);

endmodule

//--- src/adce_pkg.sv
`include "adce_cfg.svh"

package adce_pkg;

   // value written to the ADCE data register
   typedef enum logic [1:0] {
      ADCE_MODE_OFF      = 2'd0,
      ADCE_MODE_ONE_TIME = 2'd1
   } adce_mode_e;

   typedef enum logic [1:0] {
      CTLR_IDLE,
      CTLR_ON,
      CTLR_POWERDOWN
   } adce_ctlr_state_e;

   typedef enum logic [2:0] {
      SEQ_IDLE,
      SEQ_OFFSET,
      SEQ_MODE,
      SEQ_LCH,
      SEQ_GO,
      SEQ_PAUSE,
      SEQ_DONE
   } adce_seq_state_e;

   typedef struct packed {
      logic [`MGMT_ADDR_W-1:0] address;
      logic [`MGMT_DATA_W-1:0] writedata;
      logic                    write;
   } mgmt_write_t;

   typedef struct packed {
      logic       go;
      adce_mode_e mode;
   } adce_req_t;

   typedef struct packed {
      logic on_pulse;
      logic off_pulse;
   } adce_event_t;

endpackage

//--- include/adce_cfg.svh
`ifndef ADCE_CFG_SVH
`define ADCE_CFG_SVH

// transceiver reconfiguration interfaces served per run
`define ADCE_NUM_CHANNELS 10
`define ADCE_SKIP_CHANNEL 4
`define ADCE_CHAN_W       4

// 4000 ticks of ev1us, about 4 ms
`define ADCE_TIMER   4000
`define ADCE_TIMER_W 12

// equalization phase 2 and gen3 rate codes
`define LTSSM_EQ_PH2 5'h1D
`define SPEED_GEN3   2'd3

// ADCE register map on the management bus
`define ADDR_ADCE_LCH    7'h48
`define ADDR_ADCE_OFFSET 7'h4A
`define ADDR_ADCE_DATA   7'h4B
`define ADDR_ADCE_STATUS 7'h4C

`define ADCE_PAUSE_CYCLES 4

`define MGMT_ADDR_W 7
`define MGMT_DATA_W 32

`endif
